/* mem_sys_top.f */
hw/mem_sys_pkg.sv
hw/axi4_arb.sv
hw/axi4_master.sv
hw/axi4_sram.sv
hw/mem_sys_top.sv
tests/mem_sys_tb.sv

/* Bender.yml */
package:
  name: mem_sys

sources:
  - hw/mem_sys_pkg.sv
  - hw/axi4_arb.sv
  - hw/axi4_master.sv
  - hw/axi4_sram.sv
  - hw/mem_sys_top.sv
  - target: test
    files:
      - tests/mem_sys_tb.sv

/* tests/mem_sys_tb.sv */
`default_nettype none

module mem_sys_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import mem_sys_pkg::*;

  localparam int MEM_WORDS  = 1024;
  // about 110 bus beats at a worst case of 10 cycles each, with wide margin
  localparam int MAX_CYCLES = 20000;

  logic  clk;
  logic  rst;
  word_t if_read_addr_i, if_rdata_o, if_write_addr_i, if_wdata_i;
  logic  if_raddr_valid_i, if_rdata_ready_o, if_write_valid_i, if_wdata_ready_o;
  mask_t if_rmask_i, if_wmask_i;
  size_t if_rsize_i, if_wsize_i;
  len_t  if_rlen_i, if_wlen_i;
  word_t mem_read_addr_i, mem_rdata_o, mem_write_addr_i, mem_wdata_i;
  logic  mem_raddr_valid_i, mem_rdata_ready_o, mem_write_valid_i, mem_wdata_ready_o;
  mask_t mem_rmask_i, mem_wmask_i;
  size_t mem_rsize_i, mem_wsize_i;
  len_t  mem_rlen_i, mem_wlen_i;

  word_t      ref_mem [MEM_WORDS];
  word_t      mem_exp_q[$];
  word_t      if_exp_q[$];
  word_t      mem_exp_w, if_exp_w;
  word_t      single_addr [16];
  logic [31:0] rng_state;
  string      test_name;
  logic       prio_check;  // mem beats must all come before any if beat
  int         errors;
  int         checks;
  int         cycle_cnt = 0;
  arb_state_e rd_dbg, wr_dbg;

  mem_sys_top #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem_sys_top (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int word_index(input word_t addr, input int n);
    return ((addr >> 2) + n) % MEM_WORDS;
  endfunction

  // byte-wise merge of a masked write into the stored word
  function automatic word_t apply_write(input word_t old_w, input word_t new_w, input mask_t m);
    word_t res;
    res = old_w;
    for (int b = 0; b < XLEN / 8; b++) begin
      if (m[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic mem_read(input word_t addr, input len_t len);
    int beats;
    beats = 0;
    @(posedge clk);
    for (int n = 0; n <= len; n++) mem_exp_q.push_back(ref_mem[word_index(addr, n)]);
    mem_read_addr_i   <= addr;
    mem_rlen_i        <= len;
    mem_rsize_i       <= 4'd2;
    mem_rmask_i       <= 4'hf;
    mem_raddr_valid_i <= 1'b1;
    while (beats <= len) begin
      @(posedge clk);
      if (mem_rdata_ready_o) beats++;
    end
    mem_raddr_valid_i <= 1'b0;
  endtask

  task automatic mem_write(input word_t addr, input word_t data, input mask_t mask);
    @(posedge clk);
    mem_write_addr_i  <= addr;
    mem_wdata_i       <= data;
    mem_wmask_i       <= mask;
    mem_wsize_i       <= 4'd2;
    mem_wlen_i        <= '0;
    mem_write_valid_i <= 1'b1;
    @(posedge clk);
    while (!mem_wdata_ready_o) @(posedge clk);
    ref_mem[word_index(addr, 0)] = apply_write(ref_mem[word_index(addr, 0)], data, mask);
    mem_write_valid_i <= 1'b0;
  endtask

  task automatic if_read_burst(input word_t base, input len_t len);
    int beats;
    beats = 0;
    @(posedge clk);
    for (int n = 0; n <= len; n++) if_exp_q.push_back(ref_mem[word_index(base, n)]);
    if_read_addr_i   <= base;
    if_rlen_i        <= len;
    if_rsize_i       <= 4'd2;
    if_rmask_i       <= 4'hf;
    if_raddr_valid_i <= 1'b1;
    while (beats <= len) begin
      @(posedge clk);
      if (if_rdata_ready_o) beats++;
    end
    if_raddr_valid_i <= 1'b0;
  endtask

  task automatic if_write_burst(input word_t base, input len_t len);
    int    beats;
    word_t w;
    beats = 0;
    w = next_rand();
    @(posedge clk);
    if_write_addr_i  <= base;
    if_wlen_i        <= len;
    if_wsize_i       <= 4'd2;
    if_wmask_i       <= 4'hf;
    if_wdata_i       <= w;
    if_write_valid_i <= 1'b1;
    while (beats <= len) begin
      @(posedge clk);
      if (if_wdata_ready_o) begin
        ref_mem[word_index(base, beats)] = w;
        beats++;
        w = next_rand();
        if_wdata_i <= w;  // next word goes out the cycle after the pulse
      end
    end
    if_write_valid_i <= 1'b0;
  endtask

  task automatic check_idle_readies();
    checks++;
    if ({if_rdata_ready_o, if_wdata_ready_o, mem_rdata_ready_o, mem_wdata_ready_o} != 4'b0) begin
      $display("a ready output is high around reset with no request pending");
      errors++;
    end
  endtask

  // every ready pulse is checked here against the queued reference words
  always @(posedge clk) begin
    if (!rst) begin
      if (mem_rdata_ready_o) begin
        checks++;
        if (!mem_raddr_valid_i) begin
          $display("%s: mem_rdata_ready pulsed with no mem read pending", test_name);
          errors++;
        end else if (mem_exp_q.size() == 0) begin
          $display("%s: more mem read beats than requested", test_name);
          errors++;
        end else begin
          mem_exp_w = mem_exp_q.pop_front();
          if (mem_rdata_o !== mem_exp_w) begin
            $display("[FAIL] %s: mem_rdata expected %08h actual %08h",
                     test_name, mem_exp_w, mem_rdata_o);
            errors++;
          end
        end
      end
      if (if_rdata_ready_o) begin
        checks++;
        if (prio_check && mem_exp_q.size() != 0) begin
          $display("%s: if read beat arrived while mem beats were pending", test_name);
          errors++;
        end
        if (!if_raddr_valid_i) begin
          $display("%s: if_rdata_ready pulsed with no if read pending", test_name);
          errors++;
        end else if (if_exp_q.size() == 0) begin
          $display("%s: more if read beats than requested", test_name);
          errors++;
        end else begin
          if_exp_w = if_exp_q.pop_front();
          if (if_rdata_o !== if_exp_w) begin
            $display("[FAIL] %s: if_rdata expected %08h actual %08h",
                     test_name, if_exp_w, if_rdata_o);
            errors++;
          end
        end
      end
      if (if_wdata_ready_o && !if_write_valid_i) begin
        $display("%s: if_wdata_ready pulsed with no if write pending", test_name);
        errors++;
      end
      if (mem_wdata_ready_o && !mem_write_valid_i) begin
        $display("%s: mem_wdata_ready pulsed with no mem write pending", test_name);
        errors++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      rd_dbg = u_mem_sys_top.u_arb.rd_state;
      wr_dbg = u_mem_sys_top.u_arb.wr_state;
      $display("timeout in test %s, arbiter read state %s, write state %s",
               test_name, rd_dbg.name(), wr_dbg.name());
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    clk               = 1'b0;
    rst               = 1'b1;
    if_read_addr_i    = '0;
    if_raddr_valid_i  = 1'b0;
    if_rmask_i        = '0;
    if_rsize_i        = '0;
    if_rlen_i         = '0;
    if_write_addr_i   = '0;
    if_write_valid_i  = 1'b0;
    if_wmask_i        = '0;
    if_wdata_i        = '0;
    if_wsize_i        = '0;
    if_wlen_i         = '0;
    mem_read_addr_i   = '0;
    mem_raddr_valid_i = 1'b0;
    mem_rmask_i       = '0;
    mem_rsize_i       = '0;
    mem_rlen_i        = '0;
    mem_write_addr_i  = '0;
    mem_write_valid_i = 1'b0;
    mem_wmask_i       = '0;
    mem_wdata_i       = '0;
    mem_wsize_i       = '0;
    mem_wlen_i        = '0;
    rng_state         = 32'h4e72;
    errors            = 0;
    checks            = 0;
    prio_check        = 1'b0;

    test_name = "reset";
    repeat (10) @(posedge clk);
    check_idle_readies();
    rst <= 1'b0;
    repeat (3) begin
      @(posedge clk);
      check_idle_readies();
    end

    test_name = "mem_single";
    for (int i = 0; i < 16; i++) begin
      single_addr[i] = (next_rand() % 256) << 2;  // lower quarter of the array
      mem_write(single_addr[i], next_rand(), 4'hf);
    end
    for (int i = 0; i < 16; i++) mem_read(single_addr[i], 8'd0);

    test_name = "byte_mask";
    for (int i = 0; i < 16; i++) begin
      mem_write(single_addr[i], next_rand(), next_rand() % 16);
      mem_read(single_addr[i], 8'd0);
    end

    test_name = "if_burst";
    if_write_burst(512 * 4, 8'd0);
    if_write_burst(520 * 4, 8'd3);
    if_write_burst(532 * 4, 8'd7);
    if_read_burst(512 * 4, 8'd0);
    if_read_burst(520 * 4, 8'd3);
    if_read_burst(532 * 4, 8'd7);

    test_name = "priority";
    prio_check = 1'b1;
    fork
      mem_read(520 * 4, 8'd3);
      if_read_burst(532 * 4, 8'd7);
    join
    prio_check = 1'b0;

    test_name = "rw_parallel";
    fork
      if_read_burst(532 * 4, 8'd7);
      mem_write(600 * 4, next_rand(), 4'hf);  // outside the burst window
    join
    mem_read(600 * 4, 8'd0);

    repeat (5) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/mem_sys_top.sv */
`default_nettype none

module mem_sys_top #(
  parameter int MEM_WORDS = 1024
) (
  input  wire                clk,
  input  wire                rst,
  input  wire mem_sys_pkg::word_t if_read_addr_i,
  input  wire                if_raddr_valid_i,
  input  wire mem_sys_pkg::mask_t if_rmask_i,
  input  wire mem_sys_pkg::size_t if_rsize_i,
  input  wire mem_sys_pkg::len_t  if_rlen_i,
  output mem_sys_pkg::word_t if_rdata_o,
  output logic               if_rdata_ready_o,
  input  wire mem_sys_pkg::word_t if_write_addr_i,
  input  wire                if_write_valid_i,
  input  wire mem_sys_pkg::mask_t if_wmask_i,
  input  wire mem_sys_pkg::word_t if_wdata_i,
  input  wire mem_sys_pkg::size_t if_wsize_i,
  input  wire mem_sys_pkg::len_t  if_wlen_i,
  output logic               if_wdata_ready_o,
  input  wire mem_sys_pkg::word_t mem_read_addr_i,
  input  wire                mem_raddr_valid_i,
  input  wire mem_sys_pkg::mask_t mem_rmask_i,
  input  wire mem_sys_pkg::size_t mem_rsize_i,
  input  wire mem_sys_pkg::len_t  mem_rlen_i,
  output mem_sys_pkg::word_t mem_rdata_o,
  output logic               mem_rdata_ready_o,
  input  wire mem_sys_pkg::word_t mem_write_addr_i,
  input  wire                mem_write_valid_i,
  input  wire mem_sys_pkg::mask_t mem_wmask_i,
  input  wire mem_sys_pkg::word_t mem_wdata_i,
  input  wire mem_sys_pkg::size_t mem_wsize_i,
  input  wire mem_sys_pkg::len_t  mem_wlen_i,
  output logic               mem_wdata_ready_o
);
  import mem_sys_pkg::*;

  // arbiter to master
  word_t arb_read_addr, arb_rdata, arb_write_addr, arb_wdata;
  size_t arb_rsize, arb_wsize;
  len_t  arb_rlen, arb_wlen;
  mask_t arb_wmask;
  logic  arb_raddr_valid, arb_rdata_ready, arb_rlast;
  logic  arb_write_valid, arb_wdata_ready;

  // master to sram
  word_t      awaddr, wdata, araddr, rdata;
  len_t       awlen, arlen;
  logic [2:0] awsize, arsize;
  mask_t      wstrb;
  logic       awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic       arvalid, arready, rlast, rvalid, rready;

  axi4_arb u_arb (
    .clk,
    .rst,
    .if_read_addr_i,
    .if_raddr_valid_i,
    .if_rmask_i,
    .if_rsize_i,
    .if_rlen_i,
    .if_rdata_o,
    .if_rdata_ready_o,
    .if_write_addr_i,
    .if_write_valid_i,
    .if_wmask_i,
    .if_wdata_i,
    .if_wsize_i,
    .if_wlen_i,
    .if_wdata_ready_o,
    .mem_read_addr_i,
    .mem_raddr_valid_i,
    .mem_rmask_i,
    .mem_rsize_i,
    .mem_rlen_i,
    .mem_rdata_o,
    .mem_rdata_ready_o,
    .mem_write_addr_i,
    .mem_write_valid_i,
    .mem_wmask_i,
    .mem_wdata_i,
    .mem_wsize_i,
    .mem_wlen_i,
    .mem_wdata_ready_o,
    .arb_rlast_i       (arb_rlast),
    .arb_read_addr_o   (arb_read_addr),
    .arb_raddr_valid_o (arb_raddr_valid),
    .arb_rmask_o       (),  // reads always return whole words
    .arb_rsize_o       (arb_rsize),
    .arb_rlen_o        (arb_rlen),
    .arb_rdata_i       (arb_rdata),
    .arb_rdata_ready_i (arb_rdata_ready),
    .arb_write_addr_o  (arb_write_addr),
    .arb_write_valid_o (arb_write_valid),
    .arb_wmask_o       (arb_wmask),
    .arb_wdata_o       (arb_wdata),
    .arb_wsize_o       (arb_wsize),
    .arb_wlen_o        (arb_wlen),
    .arb_wdata_ready_i (arb_wdata_ready)
  );

  axi4_master u_axi (
    .clk,
    .rst,
    .arb_read_addr_i   (arb_read_addr),
    .arb_raddr_valid_i (arb_raddr_valid),
    .arb_rsize_i       (arb_rsize),
    .arb_rlen_i        (arb_rlen),
    .arb_rdata_o       (arb_rdata),
    .arb_rdata_ready_o (arb_rdata_ready),
    .arb_rlast_o       (arb_rlast),
    .arb_write_addr_i  (arb_write_addr),
    .arb_write_valid_i (arb_write_valid),
    .arb_wmask_i       (arb_wmask),
    .arb_wdata_i       (arb_wdata),
    .arb_wsize_i       (arb_wsize),
    .arb_wlen_i        (arb_wlen),
    .arb_wdata_ready_o (arb_wdata_ready),
    .awaddr_o          (awaddr),
    .awlen_o           (awlen),
    .awsize_o          (awsize),
    .awvalid_o         (awvalid),
    .awready_i         (awready),
    .wdata_o           (wdata),
    .wstrb_o           (wstrb),
    .wlast_o           (wlast),
    .wvalid_o          (wvalid),
    .wready_i          (wready),
    .bvalid_i          (bvalid),
    .bready_o          (bready),
    .araddr_o          (araddr),
    .arlen_o           (arlen),
    .arsize_o          (arsize),
    .arvalid_o         (arvalid),
    .arready_i         (arready),
    .rdata_i           (rdata),
    .rlast_i           (rlast),
    .rvalid_i          (rvalid),
    .rready_o          (rready)
  );

  axi4_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .clk,
    .rst,
    .awaddr_i  (awaddr),
    .awlen_i   (awlen),
    .awsize_i  (awsize),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .wlast_i   (wlast),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .araddr_i  (araddr),
    .arlen_i   (arlen),
    .arsize_i  (arsize),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rdata_o   (rdata),
    .rlast_o   (rlast),
    .rvalid_o  (rvalid),
    .rready_i  (rready)
  );

endmodule

`default_nettype wire

/* hw/axi4_sram.sv */
`default_nettype none

module axi4_sram #(
  parameter int MEM_WORDS = 1024
) (
  input  wire                clk,
  input  wire                rst,
  input  wire mem_sys_pkg::word_t awaddr_i,
  input  wire mem_sys_pkg::len_t  awlen_i,
  input  wire [2:0]          awsize_i,
  input  wire                awvalid_i,
  output logic               awready_o,
  input  wire mem_sys_pkg::word_t wdata_i,
  input  wire mem_sys_pkg::mask_t wstrb_i,
  input  wire                wlast_i,
  input  wire                wvalid_i,
  output logic               wready_o,
  output logic               bvalid_o,
  input  wire                bready_i,
  input  wire mem_sys_pkg::word_t araddr_i,
  input  wire mem_sys_pkg::len_t  arlen_i,
  input  wire [2:0]          arsize_i,
  input  wire                arvalid_i,
  output logic               arready_o,
  output mem_sys_pkg::word_t rdata_o,
  output logic               rlast_o,
  output logic               rvalid_o,
  input  wire                rready_i
);
  import mem_sys_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  word_t            mem [MEM_WORDS];
  axi_state_e       rd_state;
  axi_state_e       wr_state;
  logic [IDX_W-1:0] rd_idx, wr_idx;  // word index, steps once per beat
  len_t             rd_cnt, rd_len;
  len_t             wr_cnt, wr_len;

  assign arready_o = (rd_state == AXI_IDLE);
  assign rvalid_o  = (rd_state == AXI_DATA);
  assign rdata_o   = mem[rd_idx];
  assign rlast_o   = (rd_cnt == rd_len);
  assign awready_o = (wr_state == AXI_IDLE);
  assign wready_o  = (wr_state == AXI_DATA);
  assign bvalid_o  = (wr_state == AXI_RESP);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= AXI_IDLE;
      wr_state <= AXI_IDLE;
    end else begin
      case (rd_state)
        AXI_IDLE: if (arvalid_i) rd_state <= AXI_DATA;
        AXI_DATA: if (rready_i && rlast_o) rd_state <= AXI_IDLE;
        default:  rd_state <= AXI_IDLE;
      endcase
      case (wr_state)
        AXI_IDLE: if (awvalid_i) wr_state <= AXI_DATA;
        AXI_DATA: if (wvalid_i && wlast_i) wr_state <= AXI_RESP;
        AXI_RESP: if (bready_i) wr_state <= AXI_IDLE;
        default:  wr_state <= AXI_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (arready_o) begin
      rd_idx <= araddr_i[IDX_W+1:2];
      rd_len <= arlen_i;
      rd_cnt <= '0;
    end else if (rvalid_o && rready_i) begin
      rd_idx <= rd_idx + 1'b1;
      rd_cnt <= rd_cnt + 1'b1;
    end

    if (awready_o) begin
      wr_idx <= awaddr_i[IDX_W+1:2];
      wr_len <= awlen_i;
      wr_cnt <= '0;
    end else if (wready_o && wvalid_i) begin
      wr_idx <= wr_idx + 1'b1;
      wr_cnt <= wr_cnt + 1'b1;
      for (int b = 0; b < XLEN / 8; b++) begin
        if (wstrb_i[b]) begin
          mem[wr_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // word transfers only
  assert property (@(posedge clk) disable iff (rst)
    (arvalid_i |-> arsize_i == 3'd2) and (awvalid_i |-> awsize_i == 3'd2));

  // master's wlast must agree with the burst length given on AW
  assert property (@(posedge clk) disable iff (rst)
    (wready_o && wvalid_i) |-> (wlast_i == (wr_cnt == wr_len)));

endmodule

`default_nettype wire

/* hw/axi4_master.sv */
`default_nettype none

module axi4_master (
  input  wire                clk,
  input  wire                rst,
  // arbiter read side
  input  wire mem_sys_pkg::word_t arb_read_addr_i,
  input  wire                arb_raddr_valid_i,
  input  wire mem_sys_pkg::size_t arb_rsize_i,
  input  wire mem_sys_pkg::len_t  arb_rlen_i,
  output mem_sys_pkg::word_t arb_rdata_o,
  output logic               arb_rdata_ready_o,
  output logic               arb_rlast_o,
  // arbiter write side
  input  wire mem_sys_pkg::word_t arb_write_addr_i,
  input  wire                arb_write_valid_i,
  input  wire mem_sys_pkg::mask_t arb_wmask_i,
  input  wire mem_sys_pkg::word_t arb_wdata_i,
  input  wire mem_sys_pkg::size_t arb_wsize_i,
  input  wire mem_sys_pkg::len_t  arb_wlen_i,
  output logic               arb_wdata_ready_o,
  // AXI4 write channels
  output mem_sys_pkg::word_t awaddr_o,
  output mem_sys_pkg::len_t  awlen_o,
  output logic [2:0]         awsize_o,
  output logic               awvalid_o,
  input  wire                awready_i,
  output mem_sys_pkg::word_t wdata_o,
  output mem_sys_pkg::mask_t wstrb_o,
  output logic               wlast_o,
  output logic               wvalid_o,
  input  wire                wready_i,
  input  wire                bvalid_i,
  output logic               bready_o,
  // AXI4 read channels
  output mem_sys_pkg::word_t araddr_o,
  output mem_sys_pkg::len_t  arlen_o,
  output logic [2:0]         arsize_o,
  output logic               arvalid_o,
  input  wire                arready_i,
  input  wire mem_sys_pkg::word_t rdata_i,
  input  wire                rlast_i,
  input  wire                rvalid_i,
  output logic               rready_o
);
  import mem_sys_pkg::*;

  axi_state_e rd_state;
  axi_state_e wr_state;
  logic       rd_hold;    // grant already issued, wait for valid to drop
  logic       wr_hold;
  logic       wr_single;  // single beat reports on B, bursts on each W
  len_t       wr_beat;
  logic       r_fire;
  logic       w_fire;
  logic       b_fire;

  assign r_fire = rvalid_i && rready_o;
  assign w_fire = wvalid_o && wready_i;
  assign b_fire = bvalid_i && bready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= AXI_IDLE;
      rd_hold  <= 1'b0;
    end else begin
      if (!arb_raddr_valid_i) begin
        rd_hold <= 1'b0;
      end
      case (rd_state)
        AXI_IDLE: begin
          if (arb_raddr_valid_i && !rd_hold) begin
            rd_state <= AXI_ADDR;
            rd_hold  <= 1'b1;
          end
        end
        AXI_ADDR: if (arready_i) rd_state <= AXI_DATA;
        AXI_DATA: if (r_fire && rlast_i) rd_state <= AXI_IDLE;
        default:  rd_state <= AXI_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= AXI_IDLE;
      wr_hold  <= 1'b0;
    end else begin
      if (!arb_write_valid_i) begin
        wr_hold <= 1'b0;
      end
      case (wr_state)
        AXI_IDLE: begin
          if (arb_write_valid_i && !wr_hold) begin
            wr_state <= AXI_ADDR;
            wr_hold  <= 1'b1;
          end
        end
        AXI_ADDR: if (awready_i) wr_state <= AXI_DATA;
        AXI_DATA: if (w_fire && wlast_o) wr_state <= AXI_RESP;
        AXI_RESP: if (b_fire) wr_state <= AXI_IDLE;
        default:  wr_state <= AXI_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_state == AXI_IDLE) begin
      wr_single <= (arb_wlen_i == '0);
    end
    if (wr_state == AXI_ADDR) begin
      wr_beat <= '0;
    end else if (w_fire) begin
      wr_beat <= wr_beat + 1'b1;
    end
  end

  // addresses stay latched in the arbiter for the whole grant
  assign araddr_o  = arb_read_addr_i;
  assign arlen_o   = arb_rlen_i;
  assign arsize_o  = arb_rsize_i[2:0];
  assign arvalid_o = (rd_state == AXI_ADDR);
  assign rready_o  = (rd_state == AXI_DATA);

  assign awaddr_o  = arb_write_addr_i;
  assign awlen_o   = arb_wlen_i;
  assign awsize_o  = arb_wsize_i[2:0];
  assign awvalid_o = (wr_state == AXI_ADDR);
  assign wdata_o   = arb_wdata_i;
  assign wstrb_o   = arb_wmask_i;
  assign wvalid_o  = (wr_state == AXI_DATA);
  assign wlast_o   = (wr_beat == arb_wlen_i);
  assign bready_o  = (wr_state == AXI_RESP);

  assign arb_rdata_o       = rdata_i;
  assign arb_rdata_ready_o = r_fire;
  assign arb_rlast_o       = r_fire && rlast_i;
  assign arb_wdata_ready_o = wr_single ? b_fire : w_fire;

endmodule

`default_nettype wire

/* hw/axi4_arb.sv */
`default_nettype none

module axi4_arb (
  input  wire                clk,
  input  wire                rst,
  // if stage read
  input  wire mem_sys_pkg::word_t if_read_addr_i,
  input  wire                if_raddr_valid_i,
  input  wire mem_sys_pkg::mask_t if_rmask_i,
  input  wire mem_sys_pkg::size_t if_rsize_i,
  input  wire mem_sys_pkg::len_t  if_rlen_i,
  output mem_sys_pkg::word_t if_rdata_o,
  output logic               if_rdata_ready_o,
  // if stage write, burst capable
  input  wire mem_sys_pkg::word_t if_write_addr_i,
  input  wire                if_write_valid_i,
  input  wire mem_sys_pkg::mask_t if_wmask_i,
  input  wire mem_sys_pkg::word_t if_wdata_i,
  input  wire mem_sys_pkg::size_t if_wsize_i,
  input  wire mem_sys_pkg::len_t  if_wlen_i,
  output logic               if_wdata_ready_o,
  // mem stage read
  input  wire mem_sys_pkg::word_t mem_read_addr_i,
  input  wire                mem_raddr_valid_i,
  input  wire mem_sys_pkg::mask_t mem_rmask_i,
  input  wire mem_sys_pkg::size_t mem_rsize_i,
  input  wire mem_sys_pkg::len_t  mem_rlen_i,
  output mem_sys_pkg::word_t mem_rdata_o,
  output logic               mem_rdata_ready_o,
  // mem stage write, single beat
  input  wire mem_sys_pkg::word_t mem_write_addr_i,
  input  wire                mem_write_valid_i,
  input  wire mem_sys_pkg::mask_t mem_wmask_i,
  input  wire mem_sys_pkg::word_t mem_wdata_i,
  input  wire mem_sys_pkg::size_t mem_wsize_i,
  input  wire mem_sys_pkg::len_t  mem_wlen_i,
  output logic               mem_wdata_ready_o,
  // bus side
  input  wire                arb_rlast_i,
  output mem_sys_pkg::word_t arb_read_addr_o,
  output logic               arb_raddr_valid_o,
  output mem_sys_pkg::mask_t arb_rmask_o,
  output mem_sys_pkg::size_t arb_rsize_o,
  output mem_sys_pkg::len_t  arb_rlen_o,
  input  wire mem_sys_pkg::word_t arb_rdata_i,
  input  wire                arb_rdata_ready_i,
  output mem_sys_pkg::word_t arb_write_addr_o,
  output logic               arb_write_valid_o,
  output mem_sys_pkg::mask_t arb_wmask_o,
  output mem_sys_pkg::word_t arb_wdata_o,
  output mem_sys_pkg::size_t arb_wsize_o,
  output mem_sys_pkg::len_t  arb_wlen_o,
  input  wire                arb_wdata_ready_i
);
  import mem_sys_pkg::*;

  arb_state_e rd_state;
  arb_state_e wr_state;
  word_t      rd_addr, wr_addr;
  mask_t      rd_mask, wr_mask;
  size_t      rd_size, wr_size;
  len_t       rd_len, wr_len;
  len_t       wr_cnt;  // accepted write beats

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= ARB_IDLE;
      wr_state <= ARB_IDLE;
    end else begin
      case (rd_state)
        ARB_IDLE: begin
          if (mem_raddr_valid_i) begin
            rd_state <= MEM_READ;
          end else if (if_raddr_valid_i) begin
            rd_state <= IF_READ;
          end
        end
        IF_READ, MEM_READ: begin
          if (arb_rlast_i) begin
            rd_state <= ARB_IDLE;
          end
        end
        default: rd_state <= ARB_IDLE;
      endcase

      case (wr_state)
        ARB_IDLE: begin
          if (mem_write_valid_i) begin
            wr_state <= MEM_WRITE;
          end else if (if_write_valid_i) begin
            wr_state <= IF_WRITE;
          end
        end
        IF_WRITE: begin
          if (arb_wdata_ready_i && wr_cnt == wr_len) begin
            wr_state <= ARB_IDLE;
          end
        end
        MEM_WRITE: begin
          if (arb_wdata_ready_i) begin
            wr_state <= ARB_IDLE;
          end
        end
        default: wr_state <= ARB_IDLE;
      endcase
    end
  end

  // request fields track the winner while idle, frozen once granted
  always_ff @(posedge clk) begin
    if (rd_state == ARB_IDLE) begin
      rd_addr <= mem_raddr_valid_i ? mem_read_addr_i : if_read_addr_i;
      rd_mask <= mem_raddr_valid_i ? mem_rmask_i : if_rmask_i;
      rd_size <= mem_raddr_valid_i ? mem_rsize_i : if_rsize_i;
      rd_len  <= mem_raddr_valid_i ? mem_rlen_i : if_rlen_i;
    end
    if (wr_state == ARB_IDLE) begin
      wr_addr <= mem_write_valid_i ? mem_write_addr_i : if_write_addr_i;
      wr_mask <= mem_write_valid_i ? mem_wmask_i : if_wmask_i;
      wr_size <= mem_write_valid_i ? mem_wsize_i : if_wsize_i;
      wr_len  <= mem_write_valid_i ? mem_wlen_i : if_wlen_i;
      wr_cnt  <= '0;
    end else if (arb_wdata_ready_i) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  assign arb_read_addr_o   = rd_addr;
  assign arb_raddr_valid_o = (rd_state != ARB_IDLE);
  assign arb_rmask_o       = rd_mask;
  assign arb_rsize_o       = rd_size;
  assign arb_rlen_o        = rd_len;

  assign arb_write_addr_o  = wr_addr;
  assign arb_write_valid_o = (wr_state != ARB_IDLE);
  assign arb_wmask_o       = wr_mask;
  assign arb_wsize_o       = wr_size;
  assign arb_wlen_o        = wr_len;
  // live data, if bursts advance a word per ready
  assign arb_wdata_o = (wr_state == IF_WRITE)  ? if_wdata_i :
                       (wr_state == MEM_WRITE) ? mem_wdata_i : '0;

  assign if_rdata_o        = (rd_state == IF_READ)  ? arb_rdata_i : '0;
  assign if_rdata_ready_o  = (rd_state == IF_READ)  && arb_rdata_ready_i;
  assign mem_rdata_o       = (rd_state == MEM_READ) ? arb_rdata_i : '0;
  assign mem_rdata_ready_o = (rd_state == MEM_READ) && arb_rdata_ready_i;
  assign if_wdata_ready_o  = (wr_state == IF_WRITE)  && arb_wdata_ready_i;
  assign mem_wdata_ready_o = (wr_state == MEM_WRITE) && arb_wdata_ready_i;

  // the master only strobes inside a grant, so each strobe reaches one stage
  assert property (@(posedge clk) disable iff (rst)
    arb_rdata_ready_i |-> $onehot({if_rdata_ready_o, mem_rdata_ready_o}));
  assert property (@(posedge clk) disable iff (rst)
    arb_wdata_ready_i |-> $onehot({if_wdata_ready_o, mem_wdata_ready_o}));

endmodule

`default_nettype wire

/* hw/mem_sys_pkg.sv */
`default_nettype none

package mem_sys_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0]   word_t;  // bus address or data word
  typedef logic [XLEN/8-1:0] mask_t;  // one bit per byte
  typedef logic [3:0]        size_t;
  typedef logic [7:0]        len_t;   // beats minus one

  // grant owner of one arbiter channel
  typedef enum logic [2:0] {
    ARB_IDLE,
    IF_READ,
    MEM_READ,
    IF_WRITE,
    MEM_WRITE
  } arb_state_e;

  typedef enum logic [1:0] {
    AXI_IDLE,
    AXI_ADDR,
    AXI_DATA,
    AXI_RESP
  } axi_state_e;

endpackage

`default_nettype wire
